//--- verilog/tcp_rx_hdr_pkg.sv
`default_nettype none

package tcp_rx_hdr_pkg;

  ////////////////////////////////////////
  // header field widths
  ////////////////////////////////////////

  localparam int PORT_W = 16;
  localparam int SEQ_W  = 32;
  localparam int LEN_W  = 16;

  typedef logic [PORT_W-1:0] port_t; // tcp port number
  typedef logic [SEQ_W-1:0]  seq_t;  // sequence or ack number
  typedef logic [LEN_W-1:0]  len_t;  // payload length in bytes

endpackage : tcp_rx_hdr_pkg

`default_nettype wire

//--- verilog/tcp_rx_ctrl_pkg.sv
`default_nettype none

package tcp_rx_ctrl_pkg;

  // filter fsm
  typedef enum logic [1:0] {
    FLT_IDLE = 2'd0, // waiting for a header
    FLT_RECV = 2'd1, // accepted, bytes go to the buffer
    FLT_DROP = 2'd2  // rejected, bytes discarded
  } flt_state_t;

  // ack fsm
  typedef enum logic [1:0] {
    ACK_IDLE = 2'd0,
    ACK_WAIT = 2'd1, // quiet period running
    ACK_SEND = 2'd2  // ack requested
  } ack_state_t;

  localparam int ACK_TIMEOUT_DEF    = 32'd20;
  localparam int FIFO_DEPTH_LOG_DEF = 10;

endpackage : tcp_rx_ctrl_pkg

`default_nettype wire

//--- verilog/tcp_rx_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_filter
  import tcp_rx_hdr_pkg::*;
  import tcp_rx_ctrl_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG = FIFO_DEPTH_LOG_DEF
)(
  input  wire logic                  clk,
  input  wire logic                  rst,
  // parsed header
  input  wire logic                  hdr_val,
  input  wire port_t                 src_port,
  input  wire port_t                 dst_port,
  input  wire seq_t                  seq_num,
  input  wire logic                  ack_flag,
  input  wire len_t                  pld_len,
  // payload stream
  input  wire logic                  strm_val,
  input  wire logic [7:0]            strm_dat,
  input  wire logic                  strm_err,
  input  wire logic                  strm_eof,
  // control block
  input  wire port_t                 loc_port,
  input  wire port_t                 rem_port,
  input  wire logic                  connected,
  input  wire seq_t                  loc_ack,
  // buffer
  input  wire logic [FIFO_DEPTH_LOG:0] free_cnt,
  output logic                       wr,
  output logic [7:0]                 wr_dat,
  output logic                       wr_err,
  output logic                       wr_eof,
  // to ack tracking
  output logic                       seg_done,
  output len_t                       seg_len,
  output logic                       seg_err
);

  flt_state_t              state;
  logic [FIFO_DEPTH_LOG:0] room;
  logic                    port_ok;
  logic                    fits;
  logic                    accept;
  logic                    err_acc;
  len_t                    len_q;

  ////////////////////////////////////////
  // acceptance rule
  ////////////////////////////////////////

  // a write in this cycle is not yet reflected in free_cnt
  assign room    = free_cnt - {{FIFO_DEPTH_LOG{1'b0}}, wr};
  assign port_ok = (src_port == rem_port) && (dst_port == loc_port);
  assign fits    = 32'(pld_len) <= 32'(room);
  assign accept  = connected && port_ok && ack_flag && (seq_num == loc_ack) &&
                   (pld_len != '0) && fits;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= FLT_IDLE;
      wr       <= 1'b0;
      seg_done <= 1'b0;
      err_acc  <= 1'b0;
    end else begin
      wr       <= 1'b0;
      seg_done <= 1'b0;
      case (state)
        FLT_IDLE, FLT_DROP: begin
          if (hdr_val) begin
            state   <= accept ? FLT_RECV : FLT_DROP;
            err_acc <= 1'b0;
          end else if (state == FLT_DROP && strm_val && strm_eof) begin
            state <= FLT_IDLE; // end of the rejected segment
          end
        end
        FLT_RECV: begin
          if (strm_val) begin
            wr      <= 1'b1;
            err_acc <= err_acc | strm_err;
            if (strm_eof) begin
              seg_done <= 1'b1; // lines up with the last write
              state    <= FLT_IDLE;
            end
          end
        end
        default: state <= FLT_IDLE;
      endcase
    end
  end

  // payload side, qualified by wr and seg_done
  always_ff @(posedge clk) begin
    if (hdr_val) len_q <= pld_len;
    wr_dat  <= strm_dat;
    wr_err  <= strm_err;
    wr_eof  <= strm_eof;
    seg_len <= len_q;
    seg_err <= err_acc | strm_err; // err over the whole segment
  end

endmodule : tcp_rx_filter

`default_nettype wire

//--- verilog/tcp_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_fifo
  import tcp_rx_ctrl_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG = FIFO_DEPTH_LOG_DEF
)(
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    wr,
  input  wire logic [7:0]              wr_dat,
  input  wire logic                    wr_err,
  input  wire logic                    wr_eof,
  input  wire logic                    rd,
  output logic [7:0]                   rd_dat,
  output logic                         rd_err,
  output logic                         rd_eof,
  output logic                         empty,
  output logic [FIFO_DEPTH_LOG:0]      free_cnt
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG;
  localparam logic [FIFO_DEPTH_LOG:0] DEPTH_CNT = {1'b1, {FIFO_DEPTH_LOG{1'b0}}};

  logic [9:0]              mem [DEPTH]; // {eof, err, dat}
  logic [FIFO_DEPTH_LOG:0] wr_ptr;      // extra msb tells full from empty
  logic [FIFO_DEPTH_LOG:0] rd_ptr;
  logic [FIFO_DEPTH_LOG:0] wr_ptr_nxt;
  logic [FIFO_DEPTH_LOG:0] rd_ptr_nxt;

  assign wr_ptr_nxt = wr_ptr + {{FIFO_DEPTH_LOG{1'b0}}, wr};
  assign rd_ptr_nxt = rd_ptr + {{FIFO_DEPTH_LOG{1'b0}}, rd};
  assign empty      = (wr_ptr == rd_ptr);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      free_cnt <= DEPTH_CNT;
    end else begin
      wr_ptr   <= wr_ptr_nxt;
      rd_ptr   <= rd_ptr_nxt;
      free_cnt <= DEPTH_CNT - (wr_ptr_nxt - rd_ptr_nxt);
    end
  end

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr[FIFO_DEPTH_LOG-1:0]] <= {wr_eof, wr_err, wr_dat};
    if (rd) {rd_eof, rd_err, rd_dat} <= mem[rd_ptr[FIFO_DEPTH_LOG-1:0]];
  end

endmodule : tcp_rx_fifo

`default_nettype wire

//--- verilog/tcp_rx_deliver.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_deliver (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       user_ready,
  // buffer side
  input  wire logic       empty,
  input  wire logic [7:0] rd_dat,
  input  wire logic       rd_err,
  input  wire logic       rd_eof,
  output logic            rd,
  // user side
  output logic            user_val,
  output logic [7:0]      user_dat,
  output logic            user_err,
  output logic            user_eof
);

  logic pop;

  // empty does not yet see a pop that is still in flight
  assign pop = user_ready && !empty && !rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd       <= 1'b0;
      user_val <= 1'b0;
    end else begin
      rd       <= pop;
      user_val <= rd; // read data shows up one cycle after rd
    end
  end

  assign user_dat = rd_dat;
  assign user_err = rd_err;
  assign user_eof = rd_eof;

endmodule : tcp_rx_deliver

`default_nettype wire

//--- verilog/tcp_rx_ack.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_ack
  import tcp_rx_hdr_pkg::*;
  import tcp_rx_ctrl_pkg::*;
#(
  parameter int ACK_TIMEOUT = ACK_TIMEOUT_DEF
)(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic init,      // load pulse from the control block
  input  wire seq_t init_ack,
  input  wire logic connected,
  input  wire logic seg_done,
  input  wire len_t seg_len,
  input  wire logic seg_err,
  input  wire logic ack_sent,
  output seq_t      loc_ack,
  output logic      send_ack
);

  ack_state_t  state;
  logic [31:0] cnt;
  logic        seg_ok;

  assign seg_ok = seg_done && !seg_err; // errored segments are not acked

  ////////////////////////////////////////
  // local ack number
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_ack <= '0;
    end else if (init) begin
      loc_ack <= init_ack;
    end else if (seg_ok) begin
      loc_ack <= loc_ack + seq_t'(seg_len);
    end
  end

  ////////////////////////////////////////
  // delayed ack request
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ACK_IDLE;
      cnt   <= '0;
    end else if (!connected || init) begin
      state <= ACK_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ACK_IDLE: begin
          if (seg_ok) begin
            state <= ACK_WAIT;
            cnt   <= '0;
          end
        end
        ACK_WAIT: begin
          if (seg_ok) begin
            cnt <= '0; // more data, restart the quiet period
          end else if (cnt == 32'(ACK_TIMEOUT - 1)) begin
            state <= ACK_SEND;
          end else begin
            cnt <= cnt + 32'd1;
          end
        end
        ACK_SEND: begin
          if (ack_sent) state <= ACK_IDLE; // held until the ack goes out
        end
        default: state <= ACK_IDLE;
      endcase
    end
  end

  assign send_ack = (state == ACK_SEND);

endmodule : tcp_rx_ack

`default_nettype wire

//--- verilog/tcp_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_top
  import tcp_rx_hdr_pkg::*;
  import tcp_rx_ctrl_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG = FIFO_DEPTH_LOG_DEF,
  parameter int ACK_TIMEOUT    = ACK_TIMEOUT_DEF
)(
  input  wire logic       clk,
  input  wire logic       rst,
  // parsed header
  input  wire logic       hdr_val,
  input  wire port_t      src_port,
  input  wire port_t      dst_port,
  input  wire seq_t       seq_num,
  input  wire logic       ack_flag,
  input  wire len_t       pld_len,
  // payload stream
  input  wire logic       strm_val,
  input  wire logic [7:0] strm_dat,
  input  wire logic       strm_err,
  input  wire logic       strm_eof,
  // control block
  input  wire port_t      loc_port,
  input  wire port_t      rem_port,
  input  wire logic       connected,
  input  wire logic       init,
  input  wire seq_t       init_ack,
  input  wire logic       ack_sent,
  output logic            send_ack,
  output seq_t            loc_ack,
  // user stream
  input  wire logic       user_ready,
  output logic            user_val,
  output logic [7:0]      user_dat,
  output logic            user_err,
  output logic            user_eof
);

  logic                    wr;
  logic [7:0]              wr_dat;
  logic                    wr_err;
  logic                    wr_eof;
  logic [FIFO_DEPTH_LOG:0] free_cnt;
  logic                    seg_done;
  len_t                    seg_len;
  logic                    seg_err;
  logic                    rd;
  logic [7:0]              rd_dat;
  logic                    rd_err;
  logic                    rd_eof;
  logic                    empty;

  tcp_rx_filter #(
    .FIFO_DEPTH_LOG (FIFO_DEPTH_LOG)
  ) tcp_rx_filter_inst (
    .clk       (clk),
    .rst       (rst),
    .hdr_val   (hdr_val),
    .src_port  (src_port),
    .dst_port  (dst_port),
    .seq_num   (seq_num),
    .ack_flag  (ack_flag),
    .pld_len   (pld_len),
    .strm_val  (strm_val),
    .strm_dat  (strm_dat),
    .strm_err  (strm_err),
    .strm_eof  (strm_eof),
    .loc_port  (loc_port),
    .rem_port  (rem_port),
    .connected (connected),
    .loc_ack   (loc_ack),
    .free_cnt  (free_cnt),
    .wr        (wr),
    .wr_dat    (wr_dat),
    .wr_err    (wr_err),
    .wr_eof    (wr_eof),
    .seg_done  (seg_done),
    .seg_len   (seg_len),
    .seg_err   (seg_err)
  );

  tcp_rx_fifo #(
    .FIFO_DEPTH_LOG (FIFO_DEPTH_LOG)
  ) tcp_rx_fifo_inst (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .wr_dat   (wr_dat),
    .wr_err   (wr_err),
    .wr_eof   (wr_eof),
    .rd       (rd),
    .rd_dat   (rd_dat),
    .rd_err   (rd_err),
    .rd_eof   (rd_eof),
    .empty    (empty),
    .free_cnt (free_cnt)
  );

  tcp_rx_deliver tcp_rx_deliver_inst (
    .clk        (clk),
    .rst        (rst),
    .user_ready (user_ready),
    .empty      (empty),
    .rd_dat     (rd_dat),
    .rd_err     (rd_err),
    .rd_eof     (rd_eof),
    .rd         (rd),
    .user_val   (user_val),
    .user_dat   (user_dat),
    .user_err   (user_err),
    .user_eof   (user_eof)
  );

  tcp_rx_ack #(
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) tcp_rx_ack_inst (
    .clk       (clk),
    .rst       (rst),
    .init      (init),
    .init_ack  (init_ack),
    .connected (connected),
    .seg_done  (seg_done),
    .seg_len   (seg_len),
    .seg_err   (seg_err),
    .ack_sent  (ack_sent),
    .loc_ack   (loc_ack),
    .send_ack  (send_ack)
  );

endmodule : tcp_rx_top

`default_nettype wire

//--- tests/tcp_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_tb;

  localparam int          ACK_TIMEOUT    = 20;
  localparam int          FIFO_DEPTH_LOG = 6;
  localparam int          DRAIN_LIMIT    = 500;
  localparam int          ACK_LIMIT      = 3 * ACK_TIMEOUT + 40;
  localparam logic [15:0] LOC_PORT       = 16'h1f90;
  localparam logic [15:0] REM_PORT       = 16'hc350;
  localparam logic [31:0] INIT_ACK       = 32'h0001_0000;

  logic        clk;
  logic        rst;
  logic        hdr_val;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [31:0] seq_num;
  logic        ack_flag;
  logic [15:0] pld_len;
  logic        strm_val;
  logic [7:0]  strm_dat;
  logic        strm_err;
  logic        strm_eof;
  logic [15:0] loc_port;
  logic [15:0] rem_port;
  logic        connected;
  logic        init;
  logic [31:0] init_ack;
  logic        ack_sent;
  logic        send_ack;
  logic [31:0] loc_ack;
  logic        user_ready;
  logic        user_val;
  logic [7:0]  user_dat;
  logic        user_err;
  logic        user_eof;

  logic [9:0]  exp_q[$];      // {eof, err, dat}
  logic [31:0] lcg_state;
  int          errors;
  int          quiet;         // cycles since loc_ack last moved
  logic [31:0] last_loc_ack;
  logic        last_send_ack;

  tcp_rx_top #(
    .FIFO_DEPTH_LOG (FIFO_DEPTH_LOG),
    .ACK_TIMEOUT    (ACK_TIMEOUT)
  ) tcp_rx_top_inst (
    .clk        (clk),
    .rst        (rst),
    .hdr_val    (hdr_val),
    .src_port   (src_port),
    .dst_port   (dst_port),
    .seq_num    (seq_num),
    .ack_flag   (ack_flag),
    .pld_len    (pld_len),
    .strm_val   (strm_val),
    .strm_dat   (strm_dat),
    .strm_err   (strm_err),
    .strm_eof   (strm_eof),
    .loc_port   (loc_port),
    .rem_port   (rem_port),
    .connected  (connected),
    .init       (init),
    .init_ack   (init_ack),
    .ack_sent   (ack_sent),
    .send_ack   (send_ack),
    .loc_ack    (loc_ack),
    .user_ready (user_ready),
    .user_val   (user_val),
    .user_dat   (user_dat),
    .user_err   (user_err),
    .user_eof   (user_eof)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////
  // user stream and ack monitor
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst) begin
      if (user_val) begin
        assert (exp_q.size() != 0) else begin
          $display("at %0t: user byte %02h delivered with nothing expected", $time, user_dat);
          errors++;
        end
        if (exp_q.size() != 0) begin
          assert ({user_eof, user_err, user_dat} == exp_q[0]) else begin
            $display("MISMATCH at %0t: user eof/err/dat %b/%b/%02h, expected %b/%b/%02h",
                     $time, user_eof, user_err, user_dat, exp_q[0][9], exp_q[0][8],
                     exp_q[0][7:0]);
            errors++;
          end
          void'(exp_q.pop_front());
        end
      end
      if (loc_ack != last_loc_ack) quiet = 0;
      else quiet++;
      if (send_ack && !last_send_ack) begin // request just went up
        assert (quiet >= ACK_TIMEOUT) else begin
          $display("MISMATCH at %0t: send_ack rose %0d cycles after loc_ack moved",
                   $time, quiet);
          errors++;
        end
      end
      last_loc_ack  = loc_ack;
      last_send_ack = send_ack;
    end
  end

  ////////////////////////////////////////
  // test steps
  ////////////////////////////////////////

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("timeout at %0t: user stream still owes %0d bytes", $time, exp_q.size());
      errors++;
    end
  endtask

  task automatic ack_handshake();
    int n;
    n = 0;
    while (!send_ack && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (send_ack) else begin
      $display("timeout at %0t: send_ack never came up", $time);
      errors++;
    end
    repeat (3) begin
      @(negedge clk);
      assert (send_ack) else begin
        $display("MISMATCH at %0t: send_ack fell before ack_sent", $time);
        errors++;
      end
    end
    @(posedge clk);
    ack_sent <= 1'b1;
    @(posedge clk);
    ack_sent <= 1'b0;
    @(negedge clk);
    assert (!send_ack) else begin
      $display("MISMATCH at %0t: send_ack still high after ack_sent", $time);
      errors++;
    end
  endtask

  task automatic check_no_ack();
    repeat (ACK_TIMEOUT + 5) begin
      @(negedge clk);
      assert (!send_ack) else begin
        $display("MISMATCH at %0t: send_ack raised without a clean segment", $time);
        errors++;
      end
    end
  endtask

  task automatic run_segment(input logic conn, input logic [15:0] src, input logic [15:0] dst,
                             input logic [31:0] seq, input logic ack, input logic [15:0] len,
                             input logic err, input logic ready, input logic acc,
                             input logic [31:0] exp_ack);
    int   i;
    logic bad;
    @(posedge clk);
    connected <= conn;
    if (!ready) user_ready <= 1'b0; // hold bytes in the buffer
    @(posedge clk);
    hdr_val  <= 1'b1;
    src_port <= src;
    dst_port <= dst;
    seq_num  <= seq;
    ack_flag <= ack;
    pld_len  <= len;
    @(posedge clk);
    hdr_val <= 1'b0;
    for (i = 0; i < int'(len); i++) begin
      lcg_state = lcg_next(lcg_state);
      bad       = err && (i == int'(len) / 2);
      strm_val <= 1'b1;
      strm_dat <= lcg_state[23:16];
      strm_err <= bad;
      strm_eof <= (i == int'(len) - 1);
      if (acc) exp_q.push_back({(i == int'(len) - 1), bad, lcg_state[23:16]});
      @(posedge clk);
    end
    strm_val <= 1'b0;
    strm_err <= 1'b0;
    strm_eof <= 1'b0;
    // loc_ack moves one edge after the last write
    @(posedge clk);
    @(negedge clk);
    assert (loc_ack == exp_ack) else begin
      $display("MISMATCH at %0t: loc_ack %08h, expected %08h", $time, loc_ack, exp_ack);
      errors++;
    end
    if (ready) begin
      @(posedge clk);
      user_ready <= 1'b1;
      wait_drain();
    end
    if (acc && !err) ack_handshake();
    else check_no_ack();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int          fd;
    int          rc;
    int          nf;
    int          n_tests;
    int          n_failed;
    int          err_before;
    string       line;
    logic [31:0] f_conn, f_src, f_dst, f_seq, f_ack, f_len, f_err, f_rdy, f_acc, f_lack;

    clk           = 1'b0;
    errors        = 0;
    quiet         = 0;
    n_tests       = 0;
    n_failed      = 0;
    last_loc_ack  = '0;
    last_send_ack = 1'b0;
    lcg_state     = 32'hcb61_3f1b;
    rst        <= 1'b1;
    hdr_val    <= 1'b0;
    src_port   <= '0;
    dst_port   <= '0;
    seq_num    <= '0;
    ack_flag   <= 1'b0;
    pld_len    <= '0;
    strm_val   <= 1'b0;
    strm_dat   <= '0;
    strm_err   <= 1'b0;
    strm_eof   <= 1'b0;
    loc_port   <= LOC_PORT;
    rem_port   <= REM_PORT;
    connected  <= 1'b0;
    init       <= 1'b0;
    init_ack   <= '0;
    ack_sent   <= 1'b0;
    user_ready <= 1'b0;

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!user_val && !send_ack && loc_ack == '0) else begin
      $display("MISMATCH at %0t: outputs not idle after reset", $time);
      errors++;
    end

    // open the connection
    @(posedge clk);
    connected <= 1'b1;
    init      <= 1'b1;
    init_ack  <= INIT_ACK;
    @(posedge clk);
    init <= 1'b0;
    @(negedge clk);
    assert (loc_ack == INIT_ACK) else begin
      $display("MISMATCH at %0t: loc_ack %08h after init", $time, loc_ack);
      errors++;
    end

    fd = $fopen("tests/rx_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tests/rx_patterns.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc   = $fgets(line, fd);
        nf   = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_conn, f_src, f_dst,
                       f_seq, f_ack, f_len, f_err, f_rdy, f_acc, f_lack);
        if (rc > 0 && nf == 10) begin
          n_tests++;
          err_before = errors;
          run_segment(f_conn[0], f_src[15:0], f_dst[15:0], f_seq, f_ack[0], f_len[15:0],
                      f_err[0], f_rdy[0], f_acc[0], f_lack);
          if (errors == err_before) begin
            $display("test %0d: ok", n_tests);
          end else begin
            $display("test %0d: %0d errors", n_tests, errors - err_before);
            n_failed++;
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/rx_patterns.txt
# conn src dst seq ack_flag len err ready_code exp_accept exp_loc_ack, all hex
# ready_code 1 drains after the segment, 0 holds user_ready low
1 c350 1f90 00010000 1 0010 0 1 1 00010010
1 c351 1f90 00010010 1 0008 0 1 0 00010010
1 c350 1f91 00010010 1 0008 0 1 0 00010010
1 c350 1f90 00010010 0 0008 0 1 0 00010010
1 c350 1f90 00010000 1 0008 0 1 0 00010010
1 c350 1f90 00010010 1 0000 0 1 0 00010010
0 c350 1f90 00010010 1 0008 0 1 0 00010010
1 c350 1f90 00010010 1 000c 1 1 1 00010010
1 c350 1f90 00010010 1 0021 0 1 1 00010031
1 c350 1f90 00010031 1 0018 0 0 1 00010049
1 c350 1f90 00010049 1 0018 0 0 1 00010061
1 c350 1f90 00010061 1 0014 0 0 0 00010061
1 c350 1f90 00010061 1 0010 0 1 1 00010071
1 c350 1f90 00010071 1 0005 0 1 1 00010076

//--- sim.f
verilog/tcp_rx_hdr_pkg.sv
verilog/tcp_rx_ctrl_pkg.sv
verilog/tcp_rx_filter.sv
verilog/tcp_rx_fifo.sv
verilog/tcp_rx_deliver.sv
verilog/tcp_rx_ack.sv
verilog/tcp_rx_top.sv
tests/tcp_rx_tb.sv

//--- Bender.yml
package:
  name: tcp_rx

sources:
  - verilog/tcp_rx_hdr_pkg.sv
  - verilog/tcp_rx_ctrl_pkg.sv
  - verilog/tcp_rx_filter.sv
  - verilog/tcp_rx_fifo.sv
  - verilog/tcp_rx_deliver.sv
  - verilog/tcp_rx_ack.sv
  - verilog/tcp_rx_top.sv
  - target: test
    files:
      - tests/tcp_rx_tb.sv
